// ==== project.f ====
design/rv_decode_pkg.sv
design/instr_decoder.sv
design/imm_gen.sv
design/reg_file.sv
design/instr_queue.sv
design/decode_ctrl.sv
design/decode_stage.sv
test/tb_decode_stage.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - design/rv_decode_pkg.sv
  - design/instr_decoder.sv
  - design/imm_gen.sv
  - design/reg_file.sv
  - design/instr_queue.sv
  - design/decode_ctrl.sv
  - design/decode_stage.sv
  - target: test
    files:
      - test/tb_decode_stage.sv

// ==== test/tb_decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;
	localparam int TIMEOUT = 2000;  // cycles, full run needs roughly 450

	logic        clk = 1'b0;
	logic        i_rst_n;
	logic        i_instr_valid;
	logic [31:0] i_instr;
	logic [31:0] i_pc;
	logic        i_exec_credit;
	logic        i_wb_we;
	logic [4:0]  i_wb_rd;
	logic [31:0] i_wb_data;
	logic        i_exception_pending;
	logic        o_fetch_credit, o_issue_valid;
	logic [31:0] o_pc, o_rs1_data, o_rs2_data, o_imm;
	logic [4:0]  o_rd;
	logic [3:0]  o_alu_fn, o_mem_op, o_muldiv_op;
	logic [2:0]  o_fn;
	logic [1:0]  o_b_sel, o_pcselect;
	logic        o_we, o_csr_we, o_branch, o_bneq, o_jal, o_jalr, o_lui, o_auipc;
	logic        o_ecall, o_ebreak, o_mret, o_wfi, o_illegal;

	integer      seed = 32'hae346af0;
	int          cycle_cnt = 0;       // counted on falling edges
	int          fetch_returns = 0;   // o_fetch_credit pulses seen
	int          pushes = 0;
	int          issued_cnt = 0;
	int          returned_cnt = 0;    // exec credits handed back
	logic        hold_exec;           // execute keeps its slots
	logic [31:0] next_pc;
	logic [31:0] shadow [32];         // model of the register file
	logic [31:0] q_pc[$], q_instr[$], q_rs1[$], q_rs2[$];
	logic        q_exc[$], q_lat[$];
	int          q_cyc[$];

	// reference decode results
	logic [31:0] e_imm;
	logic [3:0]  e_alu_fn, e_mem_op, e_muldiv_op;
	logic [2:0]  e_fn;
	logic [1:0]  e_b_sel, e_pcselect;
	logic        e_we, e_csr_we, e_branch, e_bneq, e_jal, e_jalr, e_lui, e_auipc;
	logic        e_ecall, e_ebreak, e_mret, e_wfi, e_illegal;

	decode_stage u_decode_stage (.*);

	always #20 clk = ~clk;

	task automatic stop_failed(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else
			stop_failed($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, act));
	endtask

	// control fields straight from the encoding rules
	function automatic void ref_decode(input logic [31:0] ins, input logic exc);
		logic [6:0] op;
		logic [2:0] f3;
		logic [1:0] sz;
		logic       r, i, ld, st, br, jl, jr, lu, au, sy, md, sb;
		op = ins[6:0];
		f3 = ins[14:12];
		r  = (op == rv_decode_pkg::OP_RTYPE);
		i  = (op == rv_decode_pkg::OP_ITYPE);
		ld = (op == rv_decode_pkg::OP_LOAD);
		st = (op == rv_decode_pkg::OP_STORE);
		br = (op == rv_decode_pkg::OP_BRANCH);
		jl = (op == rv_decode_pkg::OP_JAL);
		jr = (op == rv_decode_pkg::OP_JALR);
		lu = (op == rv_decode_pkg::OP_LUI);
		au = (op == rv_decode_pkg::OP_AUIPC);
		sy = (op == rv_decode_pkg::OP_SYSTEM);
		md = r && (ins[31:25] == 7'b0000001);
		sb = sy && (f3 == 3'b000);
		e_we       = r | i | ld | jl | jr | lu | au | (sy & ~exc);
		e_csr_we   = sy;
		e_branch   = br;
		e_bneq     = br && (f3 == 3'b001);
		e_jal      = jl;
		e_jalr     = jr && (f3 == 3'b000);
		e_lui      = lu;
		e_auipc    = au;
		e_pcselect = {br | jl | e_jalr, 1'b0};
		e_ecall    = sb && (ins[31:20] == 12'h000);
		e_ebreak   = sb && (ins[31:20] == 12'h001);
		e_mret     = sb && (ins[31:20] == 12'h302);
		e_wfi      = sb && (ins[31:20] == 12'h105);
		e_illegal  = !(r | i | ld | st | br | jl | jr | lu | au | sy) && (op != 7'd0);
		if (i && f3[1:0] == 2'b01)
			e_b_sel = rv_decode_pkg::BSEL_SHAMT;
		else if (i || ld || e_jalr)
			e_b_sel = rv_decode_pkg::BSEL_IMM;
		else
			e_b_sel = rv_decode_pkg::BSEL_REG;
		if (md)
			e_fn = rv_decode_pkg::FN_MULDIV;
		else if (jl || jr)
			e_fn = rv_decode_pkg::FN_PC4;
		else if (lu)
			e_fn = rv_decode_pkg::FN_IMM;
		else if (au)
			e_fn = rv_decode_pkg::FN_AUIPC;
		else if (ld)
			e_fn = rv_decode_pkg::FN_LOAD;
		else if (sy)
			e_fn = rv_decode_pkg::FN_CSR;
		else
			e_fn = rv_decode_pkg::FN_ALU;
		// bit 30 only counts for sub and the arithmetic shift
		e_alu_fn = rv_decode_pkg::ALU_ADD;
		if ((r && !md) || i)
			e_alu_fn = {ins[30] && (f3 == 3'b101 || (r && f3 == 3'b000)), f3};
		else if (br)
			case (f3)
				3'b100:  e_alu_fn = rv_decode_pkg::ALU_SLT;
				3'b101:  e_alu_fn = rv_decode_pkg::ALU_BGE;
				3'b110:  e_alu_fn = rv_decode_pkg::ALU_SLTU;
				3'b111:  e_alu_fn = rv_decode_pkg::ALU_BGEU;
				default: e_alu_fn = rv_decode_pkg::ALU_SUB;
			endcase
		// size field: byte 10, half 01, word 11
		sz = (f3[1:0] == 2'b00) ? 2'b10 : (f3[1:0] == 2'b01) ? 2'b01 : 2'b11;
		e_mem_op = 4'b0000;
		if (ld && f3 != 3'b011 && f3 != 3'b110 && f3 != 3'b111)
			e_mem_op = {1'b0, sz, ~f3[2]};
		else if (st && f3 <= 3'b010)
			e_mem_op = {1'b1, sz, 1'b1};
		e_muldiv_op = 4'b0000;
		if (md)
			case (f3)
				3'b000:  e_muldiv_op = 4'b0011;  // mul
				3'b001:  e_muldiv_op = 4'b0101;  // mulh
				3'b010:  e_muldiv_op = 4'b0110;  // mulhsu
				3'b011:  e_muldiv_op = 4'b0111;  // mulhu
				3'b100:  e_muldiv_op = 4'b1001;
				3'b101:  e_muldiv_op = 4'b1011;
				3'b110:  e_muldiv_op = 4'b1101;
				default: e_muldiv_op = 4'b1111;  // remu
			endcase
		// immediates by arithmetic shift of the reassembled field
		if (i || ld || jr || sy)
			e_imm = $signed(ins) >>> 20;
		else if (st)
			e_imm = $signed({ins[31:25], ins[11:7], 20'd0}) >>> 20;
		else if (br)
			e_imm = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0, 19'd0}) >>> 19;
		else if (lu || au)
			e_imm = {ins[31:12], 12'd0};
		else if (jl)
			e_imm = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0, 11'd0}) >>> 11;
		else
			e_imm = 32'd0;
	endfunction

	task automatic check_issue();
		logic [31:0] ins;
		int          push_cyc;
		assert (q_instr.size() != 0) else
			stop_failed("o_issue_valid went high with no instruction outstanding");
		ins      = q_instr.pop_front();
		push_cyc = q_cyc.pop_front();
		ref_decode(ins, q_exc.pop_front());
		if (q_lat.pop_front())
			check_val("issue latency", 2, cycle_cnt - push_cyc);
		check_val("o_fetch_credit", 1, o_fetch_credit);  // same cycle as the issue
		check_val("o_pc", q_pc.pop_front(), o_pc);
		check_val("o_rd", ins[11:7], o_rd);
		check_val("o_rs1_data", q_rs1.pop_front(), o_rs1_data);
		check_val("o_rs2_data", q_rs2.pop_front(), o_rs2_data);
		check_val("o_imm", e_imm, o_imm);
		check_val("o_alu_fn", e_alu_fn, o_alu_fn);
		check_val("o_fn", e_fn, o_fn);
		check_val("o_b_sel", e_b_sel, o_b_sel);
		check_val("o_mem_op", e_mem_op, o_mem_op);
		check_val("o_muldiv_op", e_muldiv_op, o_muldiv_op);
		check_val("o_we", e_we, o_we);
		check_val("o_csr_we", e_csr_we, o_csr_we);
		check_val("o_branch", e_branch, o_branch);
		check_val("o_bneq", e_bneq, o_bneq);
		check_val("o_jal", e_jal, o_jal);
		check_val("o_jalr", e_jalr, o_jalr);
		check_val("o_lui", e_lui, o_lui);
		check_val("o_auipc", e_auipc, o_auipc);
		check_val("o_pcselect", e_pcselect, o_pcselect);
		check_val("o_ecall", e_ecall, o_ecall);
		check_val("o_ebreak", e_ebreak, o_ebreak);
		check_val("o_mret", e_mret, o_mret);
		check_val("o_wfi", e_wfi, o_wfi);
		check_val("o_illegal", e_illegal, o_illegal);
	endtask

	// outputs are stable here, mid cycle
	always @(negedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT)
			stop_failed($sformatf("timeout, run still going after %0d cycles", TIMEOUT));
		if (i_rst_n && o_fetch_credit)
			fetch_returns = fetch_returns + 1;
		if (i_rst_n && o_issue_valid) begin
			issued_cnt = issued_cnt + 1;
			check_issue();
		end
	end

	// execute side frees each slot right away unless held
	always @(posedge clk) begin
		if (!i_rst_n) begin
			i_exec_credit <= 1'b0;
		end else if (!hold_exec && issued_cnt > returned_cnt) begin
			i_exec_credit <= 1'b1;
			returned_cnt = returned_cnt + 1;
		end else begin
			i_exec_credit <= 1'b0;
		end
	end

	function automatic logic [4:0] rnd_reg();
		logic [31:0] v;
		v = $random(seed);
		return v[4:0];
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2, rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_decode_pkg::OP_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1,
		input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_decode_pkg::OP_BRANCH};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_decode_pkg::OP_JAL};
	endfunction

	// drive one push once fetch holds a credit, returns on the push edge
	task automatic push_instr(input logic [31:0] ins, input logic exc, input logic lat);
		@(posedge clk);
		while (rv_decode_pkg::QUEUE_DEPTH + fetch_returns - pushes == 0)
			@(posedge clk);
		pushes = pushes + 1;
		i_instr_valid       <= 1'b1;
		i_instr             <= ins;
		i_pc                <= next_pc;
		i_exception_pending <= 1'b0;
		q_pc.push_back(next_pc);
		q_instr.push_back(ins);
		q_rs1.push_back(shadow[ins[19:15]]);
		q_rs2.push_back(shadow[ins[24:20]]);
		q_exc.push_back(exc);
		q_lat.push_back(lat);
		q_cyc.push_back(cycle_cnt + 1);  // edge that takes the push
		next_pc = next_pc + 4;
		@(posedge clk);
		i_instr_valid       <= 1'b0;
		i_exception_pending <= exc;      // held through the pop cycle
	endtask

	task automatic drain();
		@(posedge clk);
		while (q_instr.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);       // let the exec credit land
		i_exception_pending <= 1'b0;
	endtask

	task automatic issue_one(input logic [31:0] ins);
		push_instr(ins, 1'b0, 1'b1);
		drain();
	endtask

	task automatic wb_write(input logic [4:0] rd, input logic [31:0] data);
		@(posedge clk);
		i_wb_we   <= 1'b1;
		i_wb_rd   <= rd;
		i_wb_data <= data;
		if (rd != 5'd0)
			shadow[rd] = data;           // x0 stays zero
		@(posedge clk);
		i_wb_we <= 1'b0;
	endtask

	task automatic test_alu();
		logic [11:0] imm;
		logic [4:0]  a;
		logic [31:0] data;
		for (int k = 0; k < 32; k++)
			wb_write(k, $random(seed));
		for (int f = 0; f < 8; f++)
			issue_one(enc_r(7'h00, rnd_reg(), rnd_reg(), f, rnd_reg(), rv_decode_pkg::OP_RTYPE));
		issue_one(enc_r(7'h20, rnd_reg(), rnd_reg(), 3'b000, rnd_reg(), rv_decode_pkg::OP_RTYPE));
		issue_one(enc_r(7'h20, rnd_reg(), rnd_reg(), 3'b101, rnd_reg(), rv_decode_pkg::OP_RTYPE));
		for (int f = 0; f < 8; f++) begin
			imm = $random(seed);
			if (f == 1 || f == 5)
				imm[11:5] = 7'h00;           // shamt form
			issue_one(enc_i(imm, rnd_reg(), f, rnd_reg(), rv_decode_pkg::OP_ITYPE));
		end
		issue_one(enc_i(12'h407, rnd_reg(), 3'b101, rnd_reg(), rv_decode_pkg::OP_ITYPE));  // srai
		issue_one(enc_r(7'h00, 5'd0, 5'd0, 3'b000, rnd_reg(), rv_decode_pkg::OP_RTYPE));
		// writeback lands in the pop cycle, read must see it
		a    = rnd_reg() | 5'd1;
		data = $random(seed);
		shadow[a] = data;
		push_instr(enc_r(7'h00, a, a, 3'b000, rnd_reg(), rv_decode_pkg::OP_RTYPE), 1'b0, 1'b1);
		i_wb_we   <= 1'b1;
		i_wb_rd   <= a;
		i_wb_data <= data;
		@(posedge clk);
		i_wb_we <= 1'b0;
		drain();
	endtask

	task automatic test_mem();
		for (int f = 0; f < 6; f++) begin
			if (f == 3)
				continue;
			issue_one(enc_i($random(seed), rnd_reg(), f, rnd_reg(), rv_decode_pkg::OP_LOAD));
		end
		for (int f = 0; f < 3; f++)
			issue_one(enc_s($random(seed), rnd_reg(), rnd_reg(), f));
	endtask

	task automatic test_ctrl();
		for (int f = 0; f < 8; f++) begin
			if (f == 2 || f == 3)
				continue;
			issue_one(enc_b($random(seed), rnd_reg(), rnd_reg(), f));
		end
		issue_one(enc_j($random(seed), rnd_reg()));
		issue_one(enc_j(21'h1ffffe, rnd_reg()));  // jump back by 2
		issue_one(enc_i($random(seed), rnd_reg(), 3'b000, rnd_reg(), rv_decode_pkg::OP_JALR));
		issue_one({20'hfedcb, rnd_reg(), rv_decode_pkg::OP_LUI});
		issue_one({20'h12345, rnd_reg(), rv_decode_pkg::OP_AUIPC});
	endtask

	task automatic test_muldiv();
		for (int f = 0; f < 8; f++)
			issue_one(enc_r(7'h01, rnd_reg(), rnd_reg(), f, rnd_reg(), rv_decode_pkg::OP_RTYPE));
	endtask

	task automatic test_system();
		issue_one(enc_i(12'h000, 5'd0, 3'b000, 5'd0, rv_decode_pkg::OP_SYSTEM));  // ecall
		issue_one(enc_i(12'h001, 5'd0, 3'b000, 5'd0, rv_decode_pkg::OP_SYSTEM));
		issue_one(enc_i(12'h302, 5'd0, 3'b000, 5'd0, rv_decode_pkg::OP_SYSTEM));  // mret
		issue_one(enc_i(12'h105, 5'd0, 3'b000, 5'd0, rv_decode_pkg::OP_SYSTEM));
		push_instr(enc_i(12'h000, 5'd0, 3'b000, 5'd0, rv_decode_pkg::OP_SYSTEM), 1'b1, 1'b1);
		drain();
		issue_one(32'h0000_107f);        // opcode 1111111
		issue_one(32'h0000_000f);        // fence, not decoded here
		issue_one(32'h0000_0000);        // bubble, legal
	endtask

	task automatic test_credits();
		int iss0, ret0;
		iss0 = issued_cnt;
		ret0 = fetch_returns;
		@(negedge clk) hold_exec = 1'b1;
		push_instr(enc_r(7'h00, rnd_reg(), rnd_reg(), 3'b000, rnd_reg(), rv_decode_pkg::OP_RTYPE),
			1'b0, 1'b1);
		push_instr(enc_i($random(seed), rnd_reg(), 3'b110, rnd_reg(), rv_decode_pkg::OP_ITYPE),
			1'b0, 1'b1);
		// these two wait behind the empty credit counter
		push_instr(enc_s($random(seed), rnd_reg(), rnd_reg(), 3'b010), 1'b0, 1'b0);
		push_instr(enc_r(7'h01, rnd_reg(), rnd_reg(), 3'b100, rnd_reg(), rv_decode_pkg::OP_RTYPE),
			1'b0, 1'b0);
		repeat (20) @(posedge clk);
		check_val("issues while held", rv_decode_pkg::EXEC_CREDITS, issued_cnt - iss0);
		check_val("fetch credits while held", rv_decode_pkg::EXEC_CREDITS, fetch_returns - ret0);
		@(negedge clk) hold_exec = 1'b0;
		drain();
	endtask

	initial begin
		i_rst_n             = 1'b0;
		i_instr_valid       = 1'b0;
		i_instr             = 32'd0;
		i_pc                = 32'd0;
		i_exec_credit       = 1'b0;
		i_wb_we             = 1'b0;
		i_wb_rd             = 5'd0;
		i_wb_data           = 32'd0;
		i_exception_pending = 1'b0;
		hold_exec           = 1'b0;
		next_pc             = 32'h0000_1000;
		for (int k = 0; k < 32; k++)
			shadow[k] = 32'd0;
		repeat (2) @(posedge clk);
		i_rst_n <= 1'b1;
		@(negedge clk);
		check_val("o_issue_valid", 0, o_issue_valid);
		check_val("o_fetch_credit", 0, o_fetch_credit);
		test_alu();
		test_mem();
		test_ctrl();
		test_muldiv();
		test_system();
		test_credits();
		check_val("fetch credits returned", pushes, fetch_returns);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                                 clk,
	input  logic                                 i_rst_n,
	// fetch
	input  logic                                 i_instr_valid,
	input  logic [rv_decode_pkg::XLEN-1:0]       i_instr,
	input  logic [rv_decode_pkg::XLEN-1:0]       i_pc,
	output logic                                 o_fetch_credit,
	// execute
	input  logic                                 i_exec_credit,
	output logic                                 o_issue_valid,
	output logic [rv_decode_pkg::XLEN-1:0]       o_pc,
	output logic [rv_decode_pkg::REG_ADDR_W-1:0] o_rd,
	output logic [rv_decode_pkg::XLEN-1:0]       o_rs1_data,
	output logic [rv_decode_pkg::XLEN-1:0]       o_rs2_data,
	output logic [rv_decode_pkg::XLEN-1:0]       o_imm,
	output logic [3:0]                           o_alu_fn,
	output logic [2:0]                           o_fn,
	output logic [1:0]                           o_b_sel,
	output logic [3:0]                           o_mem_op,
	output logic [3:0]                           o_muldiv_op,
	output logic                                 o_we,
	output logic                                 o_csr_we,
	output logic                                 o_branch,
	output logic                                 o_bneq,
	output logic                                 o_jal,
	output logic                                 o_jalr,
	output logic                                 o_lui,
	output logic                                 o_auipc,
	output logic [1:0]                           o_pcselect,
	output logic                                 o_ecall,
	output logic                                 o_ebreak,
	output logic                                 o_mret,
	output logic                                 o_wfi,
	output logic                                 o_illegal,
	// writeback and commit
	input  logic                                 i_wb_we,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] i_wb_rd,
	input  logic [rv_decode_pkg::XLEN-1:0]       i_wb_data,
	input  logic                                 i_exception_pending
);
	logic                           not_empty, pop;
	logic [rv_decode_pkg::XLEN-1:0] head_pc, head_instr, d_imm, rs1_data, rs2_data;
	logic [3:0]                     d_alu_fn, d_mem_op, d_muldiv_op;
	logic [2:0]                     d_fn;
	logic [1:0]                     d_b_sel, d_pcselect;
	logic d_we, d_csr_we, d_branch, d_bneq, d_jal, d_jalr, d_lui, d_auipc;
	logic d_ecall, d_ebreak, d_mret, d_wfi, d_illegal;

	instr_queue u_instr_queue (
		.clk          (clk),
		.i_rst_n      (i_rst_n),
		.i_push       (i_instr_valid),  // fetch only pushes on a held credit
		.i_pc         (i_pc),
		.i_instr      (i_instr),
		.i_pop        (pop),
		.o_not_empty  (not_empty),
		.o_head_pc    (head_pc),
		.o_head_instr (head_instr)
	);

	decode_ctrl u_decode_ctrl (
		.clk            (clk),
		.i_rst_n        (i_rst_n),
		.i_not_empty    (not_empty),
		.i_exec_credit  (i_exec_credit),
		.o_pop          (pop),
		.o_issue_valid  (o_issue_valid),
		.o_fetch_credit (o_fetch_credit)
	);

	// head entry decoded straight out of the queue
	instr_decoder u_instr_decoder (
		.i_op                (head_instr[6:0]),
		.i_funct3            (head_instr[14:12]),
		.i_funct7            (head_instr[31:25]),
		.i_funct12           (head_instr[31:20]),
		.i_exception_pending (i_exception_pending),  // sampled at pop
		.o_b_sel             (d_b_sel),
		.o_we                (d_we),
		.o_fn                (d_fn),
		.o_alu_fn            (d_alu_fn),
		.o_branch            (d_branch),
		.o_bneq              (d_bneq),
		.o_jal               (d_jal),
		.o_jalr              (d_jalr),
		.o_lui               (d_lui),
		.o_auipc             (d_auipc),
		.o_mem_op            (d_mem_op),
		.o_muldiv_op         (d_muldiv_op),
		.o_pcselect          (d_pcselect),
		.o_csr_we            (d_csr_we),
		.o_ecall             (d_ecall),
		.o_ebreak            (d_ebreak),
		.o_mret              (d_mret),
		.o_wfi               (d_wfi),
		.o_illegal           (d_illegal)
	);

	imm_gen u_imm_gen (
		.i_instr (head_instr),
		.o_imm   (d_imm)
	);

	reg_file u_reg_file (
		.clk        (clk),
		.i_rst_n    (i_rst_n),
		.i_rs1      (head_instr[19:15]),
		.i_rs2      (head_instr[24:20]),
		.i_we       (i_wb_we),
		.i_rd       (i_wb_rd),
		.i_wdata    (i_wb_data),
		.o_rs1_data (rs1_data),
		.o_rs2_data (rs2_data)
	);

	// issue registers, qualified by o_issue_valid
	always_ff @(posedge clk) begin
		if (pop) begin
			o_pc        <= head_pc;
			o_rd        <= head_instr[11:7];
			o_rs1_data  <= rs1_data;
			o_rs2_data  <= rs2_data;
			o_imm       <= d_imm;
			o_alu_fn    <= d_alu_fn;
			o_fn        <= d_fn;
			o_b_sel     <= d_b_sel;
			o_mem_op    <= d_mem_op;
			o_muldiv_op <= d_muldiv_op;
			o_we        <= d_we;
			o_csr_we    <= d_csr_we;
			o_branch    <= d_branch;
			o_bneq      <= d_bneq;
			o_jal       <= d_jal;
			o_jalr      <= d_jalr;
			o_lui       <= d_lui;
			o_auipc     <= d_auipc;
			o_pcselect  <= d_pcselect;
			o_ecall     <= d_ecall;
			o_ebreak    <= d_ebreak;
			o_mret      <= d_mret;
			o_wfi       <= d_wfi;
			o_illegal   <= d_illegal;
		end
	end

endmodule

`default_nettype wire

// ==== design/decode_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
	input  logic clk,
	input  logic i_rst_n,
	input  logic i_not_empty,
	input  logic i_exec_credit,   // one credit back per high cycle
	output logic o_pop,           // also the issue register enable
	output logic o_issue_valid,
	output logic o_fetch_credit
);
	logic [rv_decode_pkg::CREDIT_W-1:0] credits;  // execute slots we may fill
	logic                               pop_q;

	assign o_pop = i_not_empty & (credits != '0);

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			credits <= rv_decode_pkg::CREDIT_W'(rv_decode_pkg::EXEC_CREDITS);
			pop_q   <= 1'b0;
		end else begin
			pop_q <= o_pop;
			// return and spend together cancel out
			if (i_exec_credit && !o_pop)
				credits <= credits + 1'b1;
			else if (o_pop && !i_exec_credit)
				credits <= credits - 1'b1;
		end
	end

	// issue and fetch credit both follow the pop by one cycle
	assign o_issue_valid  = pop_q;
	assign o_fetch_credit = pop_q;

endmodule

`default_nettype wire

// ==== design/instr_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_queue (
	input  logic                           clk,
	input  logic                           i_rst_n,
	input  logic                           i_push,
	input  logic [rv_decode_pkg::XLEN-1:0] i_pc,
	input  logic [rv_decode_pkg::XLEN-1:0] i_instr,
	input  logic                           i_pop,
	output logic                           o_not_empty,
	output logic [rv_decode_pkg::XLEN-1:0] o_head_pc,
	output logic [rv_decode_pkg::XLEN-1:0] o_head_instr
);
	logic [rv_decode_pkg::XLEN-1:0]                pc_mem    [rv_decode_pkg::QUEUE_DEPTH];
	logic [rv_decode_pkg::XLEN-1:0]                instr_mem [rv_decode_pkg::QUEUE_DEPTH];
	logic [$clog2(rv_decode_pkg::QUEUE_DEPTH)-1:0] wr_ptr, rd_ptr;
	logic [$clog2(rv_decode_pkg::QUEUE_DEPTH+1)-1:0] count;

	// entry storage, written behind the tail
	always_ff @(posedge clk) begin
		if (i_push) begin
			pc_mem[wr_ptr]    <= i_pc;
			instr_mem[wr_ptr] <= i_instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (i_push)
				wr_ptr <= (wr_ptr == rv_decode_pkg::QUEUE_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= (rd_ptr == rv_decode_pkg::QUEUE_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			if (i_push && !i_pop)
				count <= count + 1'b1;
			else if (i_pop && !i_push)
				count <= count - 1'b1;
		end
	end

	// fetch credits keep count <= depth
	assign o_not_empty  = (count != '0);
	assign o_head_pc    = pc_mem[rd_ptr];
	assign o_head_instr = instr_mem[rd_ptr];

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                                 clk,
	input  logic                                 i_rst_n,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] i_rs1,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] i_rs2,
	input  logic                                 i_we,
	input  logic [rv_decode_pkg::REG_ADDR_W-1:0] i_rd,
	input  logic [rv_decode_pkg::XLEN-1:0]       i_wdata,
	output logic [rv_decode_pkg::XLEN-1:0]       o_rs1_data,
	output logic [rv_decode_pkg::XLEN-1:0]       o_rs2_data
);
	logic [rv_decode_pkg::XLEN-1:0] regs [1:31];  // no storage for x0
	logic                           wr_ok;

	assign wr_ok = i_we & (i_rd != '0);  // x0 writes dropped

	always_ff @(posedge clk) begin
		if (!i_rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_ok) begin
			regs[i_rd] <= i_wdata;
		end
	end

	// write-first: same cycle write shows on the read port
	always_comb begin
		if (i_rs1 == '0)
			o_rs1_data = '0;
		else if (wr_ok && i_rd == i_rs1)
			o_rs1_data = i_wdata;
		else
			o_rs1_data = regs[i_rs1];
		if (i_rs2 == '0)
			o_rs2_data = '0;
		else if (wr_ok && i_rd == i_rs2)
			o_rs2_data = i_wdata;
		else
			o_rs2_data = regs[i_rs2];
	end

endmodule

`default_nettype wire

// ==== design/imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
	input  logic [rv_decode_pkg::XLEN-1:0] i_instr,
	output logic [rv_decode_pkg::XLEN-1:0] o_imm
);
	logic sign;  // instr[31], top of every format

	assign sign = i_instr[31];

	always_comb begin
		case (i_instr[6:0])
			// I format
			rv_decode_pkg::OP_ITYPE, rv_decode_pkg::OP_LOAD,
			rv_decode_pkg::OP_JALR, rv_decode_pkg::OP_SYSTEM:
				o_imm = {{20{sign}}, i_instr[31:20]};
			rv_decode_pkg::OP_STORE:
				o_imm = {{20{sign}}, i_instr[31:25], i_instr[11:7]};
			// B, bit 0 always zero
			rv_decode_pkg::OP_BRANCH:
				o_imm = {{19{sign}}, sign, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
			rv_decode_pkg::OP_LUI, rv_decode_pkg::OP_AUIPC:
				o_imm = {i_instr[31:12], 12'h000};
			// J, scrambled 20 bit offset
			rv_decode_pkg::OP_JAL:
				o_imm = {{11{sign}}, sign, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
			default:
				o_imm = '0;  // R-type has none
		endcase
	end

endmodule

`default_nettype wire

// ==== design/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  logic [6:0]  i_op,
	input  logic [2:0]  i_funct3,
	input  logic [6:0]  i_funct7,             // bit 5 is instr[30]
	input  logic [11:0] i_funct12,
	input  logic        i_exception_pending,  // from commit
	output logic [1:0]  o_b_sel,
	output logic        o_we,
	output logic [2:0]  o_fn,
	output logic [3:0]  o_alu_fn,
	output logic        o_branch,
	output logic        o_bneq,
	output logic        o_jal,
	output logic        o_jalr,
	output logic        o_lui,
	output logic        o_auipc,
	output logic [3:0]  o_mem_op,
	output logic [3:0]  o_muldiv_op,
	output logic [1:0]  o_pcselect,
	output logic        o_csr_we,
	output logic        o_ecall,
	output logic        o_ebreak,
	output logic        o_mret,
	output logic        o_wfi,
	output logic        o_illegal
);
	logic rtype, itype, ltype, stype, btype, jtype, jrtype, utype, autype, system;
	logic muldiv;    // funct7 == 0000001 on an R-type
	logic alt;       // instr[30], sub / sra
	logic sys_base;  // system with funct3 000

	assign rtype  = (i_op == rv_decode_pkg::OP_RTYPE);
	assign itype  = (i_op == rv_decode_pkg::OP_ITYPE);
	assign ltype  = (i_op == rv_decode_pkg::OP_LOAD);
	assign stype  = (i_op == rv_decode_pkg::OP_STORE);
	assign btype  = (i_op == rv_decode_pkg::OP_BRANCH);
	assign jtype  = (i_op == rv_decode_pkg::OP_JAL);
	assign jrtype = (i_op == rv_decode_pkg::OP_JALR);
	assign utype  = (i_op == rv_decode_pkg::OP_LUI);
	assign autype = (i_op == rv_decode_pkg::OP_AUIPC);
	assign system = (i_op == rv_decode_pkg::OP_SYSTEM);

	assign muldiv   = rtype & (i_funct7 == 7'b0000001);
	assign alt      = i_funct7[5];
	assign sys_base = system & (i_funct3 == 3'b000);

	// machine mode only, funct12 picks the op
	assign o_ecall  = sys_base & (i_funct12 == 12'h000);
	assign o_ebreak = sys_base & (i_funct12 == 12'h001);
	assign o_mret   = sys_base & (i_funct12 == 12'h302);
	assign o_wfi    = sys_base & (i_funct12 == 12'h105);
	assign o_csr_we = system;

	// all-zero opcode is a bubble, not illegal
	assign o_illegal = ~(rtype | itype | ltype | stype | btype | jtype | jrtype |
		utype | autype | system | (i_op == 7'b0000000));

	assign o_branch   = btype;
	assign o_bneq     = btype & (i_funct3 == 3'b001);
	assign o_jal      = jtype;
	assign o_jalr     = jrtype & (i_funct3 == 3'b000);
	assign o_lui      = utype;
	assign o_auipc    = autype;
	assign o_pcselect = {btype | o_jal | o_jalr, 1'b0};  // bit 0 spare for now

	// system writes back only when commit has nothing pending
	assign o_we = rtype | itype | ltype | jtype | jrtype | utype | autype |
		(system & ~i_exception_pending);

	always_comb begin
		o_b_sel = rv_decode_pkg::BSEL_REG;  // R-type, store, branch
		if (itype && i_funct3[1:0] == 2'b01)
			o_b_sel = rv_decode_pkg::BSEL_SHAMT;  // slli srli srai
		else if (itype || ltype || o_jalr)
			o_b_sel = rv_decode_pkg::BSEL_IMM;
	end

	always_comb begin
		o_alu_fn = rv_decode_pkg::ALU_ADD;  // address add for mem and jumps
		if ((rtype && !muldiv) || itype) begin
			case (i_funct3)
				3'b000: o_alu_fn = (rtype && alt) ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
				3'b001: o_alu_fn = rv_decode_pkg::ALU_SLL;
				3'b010: o_alu_fn = rv_decode_pkg::ALU_SLT;
				3'b011: o_alu_fn = rv_decode_pkg::ALU_SLTU;
				3'b100: o_alu_fn = rv_decode_pkg::ALU_XOR;
				3'b101: o_alu_fn = alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
				3'b110: o_alu_fn = rv_decode_pkg::ALU_OR;
				default: o_alu_fn = rv_decode_pkg::ALU_AND;
			endcase
		end else if (btype) begin
			case (i_funct3)
				3'b100: o_alu_fn = rv_decode_pkg::ALU_SLT;   // blt
				3'b101: o_alu_fn = rv_decode_pkg::ALU_BGE;
				3'b110: o_alu_fn = rv_decode_pkg::ALU_SLTU;  // bltu
				3'b111: o_alu_fn = rv_decode_pkg::ALU_BGEU;
				default: o_alu_fn = rv_decode_pkg::ALU_SUB;  // beq bne compare
			endcase
		end
	end

	always_comb begin
		o_mem_op = rv_decode_pkg::MEM_NONE;
		if (ltype) begin
			case (i_funct3)
				3'b000: o_mem_op = rv_decode_pkg::MEM_LB;
				3'b001: o_mem_op = rv_decode_pkg::MEM_LH;
				3'b010: o_mem_op = rv_decode_pkg::MEM_LW;
				3'b100: o_mem_op = rv_decode_pkg::MEM_LBU;
				3'b101: o_mem_op = rv_decode_pkg::MEM_LHU;
				default: o_mem_op = rv_decode_pkg::MEM_NONE;
			endcase
		end else if (stype) begin
			case (i_funct3)
				3'b000: o_mem_op = rv_decode_pkg::MEM_SB;
				3'b001: o_mem_op = rv_decode_pkg::MEM_SH;
				3'b010: o_mem_op = rv_decode_pkg::MEM_SW;
				default: o_mem_op = rv_decode_pkg::MEM_NONE;
			endcase
		end
	end

	always_comb begin
		o_muldiv_op = rv_decode_pkg::MULDIV_NONE;
		if (muldiv) begin
			case (i_funct3)
				3'b000: o_muldiv_op = rv_decode_pkg::MULDIV_MUL;
				3'b001: o_muldiv_op = rv_decode_pkg::MULDIV_MULH;
				3'b010: o_muldiv_op = rv_decode_pkg::MULDIV_MULHSU;
				3'b011: o_muldiv_op = rv_decode_pkg::MULDIV_MULHU;
				3'b100: o_muldiv_op = rv_decode_pkg::MULDIV_DIV;
				3'b101: o_muldiv_op = rv_decode_pkg::MULDIV_DIVU;
				3'b110: o_muldiv_op = rv_decode_pkg::MULDIV_REM;
				default: o_muldiv_op = rv_decode_pkg::MULDIV_REMU;
			endcase
		end
	end

	// which unit's result goes back to the regfile
	always_comb begin
		if (muldiv)
			o_fn = rv_decode_pkg::FN_MULDIV;
		else if (jtype || jrtype)
			o_fn = rv_decode_pkg::FN_PC4;  // link value
		else if (utype)
			o_fn = rv_decode_pkg::FN_IMM;
		else if (autype)
			o_fn = rv_decode_pkg::FN_AUIPC;
		else if (ltype)
			o_fn = rv_decode_pkg::FN_LOAD;
		else if (system)
			o_fn = rv_decode_pkg::FN_CSR;
		else
			o_fn = rv_decode_pkg::FN_ALU;
	end

endmodule

`default_nettype wire

// ==== design/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

	// widths and capacities
	localparam int XLEN         = 32;
	localparam int REG_ADDR_W   = 5;
	localparam int QUEUE_DEPTH  = 2;   // also fetch's starting credits
	localparam int EXEC_CREDITS = 2;
	localparam int CREDIT_W     = 2;

	// major opcodes
	localparam logic [6:0] OP_RTYPE  = 7'b0110011;
	localparam logic [6:0] OP_ITYPE  = 7'b0010011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	// writeback result select
	localparam logic [2:0] FN_ALU    = 3'b000;
	localparam logic [2:0] FN_PC4    = 3'b001;
	localparam logic [2:0] FN_MULDIV = 3'b010;
	localparam logic [2:0] FN_IMM    = 3'b011;
	localparam logic [2:0] FN_LOAD   = 3'b100;
	localparam logic [2:0] FN_AUIPC  = 3'b101;
	localparam logic [2:0] FN_CSR    = 3'b110;

	// alu ops, {instr[30], funct3} for most
	localparam logic [3:0] ALU_ADD  = 4'b0000;
	localparam logic [3:0] ALU_SLL  = 4'b0001;
	localparam logic [3:0] ALU_SLT  = 4'b0010;  // blt too
	localparam logic [3:0] ALU_SLTU = 4'b0011;  // bltu too
	localparam logic [3:0] ALU_XOR  = 4'b0100;
	localparam logic [3:0] ALU_SRL  = 4'b0101;
	localparam logic [3:0] ALU_OR   = 4'b0110;
	localparam logic [3:0] ALU_AND  = 4'b0111;
	localparam logic [3:0] ALU_SUB  = 4'b1000;  // beq, bne
	localparam logic [3:0] ALU_BGE  = 4'b1001;
	localparam logic [3:0] ALU_BGEU = 4'b1010;
	localparam logic [3:0] ALU_SRA  = 4'b1101;

	// mem op: [3] store, [2:1] size (11 w, 01 h, 10 b), [0] signed
	localparam logic [3:0] MEM_NONE = 4'b0000;
	localparam logic [3:0] MEM_LW   = 4'b0111;
	localparam logic [3:0] MEM_LH   = 4'b0011;
	localparam logic [3:0] MEM_LHU  = 4'b0010;
	localparam logic [3:0] MEM_LB   = 4'b0101;
	localparam logic [3:0] MEM_LBU  = 4'b0100;
	localparam logic [3:0] MEM_SW   = 4'b1111;
	localparam logic [3:0] MEM_SH   = 4'b1011;
	localparam logic [3:0] MEM_SB   = 4'b1101;

	// m extension ops
	localparam logic [3:0] MULDIV_NONE   = 4'b0000;
	localparam logic [3:0] MULDIV_MUL    = 4'b0011;
	localparam logic [3:0] MULDIV_MULH   = 4'b0101;
	localparam logic [3:0] MULDIV_MULHU  = 4'b0111;
	localparam logic [3:0] MULDIV_MULHSU = 4'b0110;
	localparam logic [3:0] MULDIV_DIV    = 4'b1001;
	localparam logic [3:0] MULDIV_DIVU   = 4'b1011;
	localparam logic [3:0] MULDIV_REM    = 4'b1101;
	localparam logic [3:0] MULDIV_REMU   = 4'b1111;

	// operand b select
	localparam logic [1:0] BSEL_REG   = 2'b00;
	localparam logic [1:0] BSEL_IMM   = 2'b01;
	localparam logic [1:0] BSEL_SHAMT = 2'b10;

endpackage

`default_nettype wire
